//--- makehint_top.f
src/makehint_pkg.sv
src/hint_gen.sv
src/hint_index_buffer.sv
src/makehint_fsm.sv
src/makehint_counter.sv
src/hint_writer.sv
src/makehint_top.sv
sim/makehint_checker.sv
sim/tb_makehint.sv

//--- Makefile
# Verilator build and run of the hint packing testbench

LOG = sim.log

all: run

build:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_makehint \
		-f makehint_top.f -o sim_makehint

run: build
	./obj_dir/sim_makehint > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Something failed" $(LOG); then echo "Simulation FAILED"; exit 1; fi
	@grep -q "Everything OK" $(LOG) || (echo "Simulation ended without a verdict"; exit 1)

lint:
	verilator --lint-only -Wall --timing --top-module tb_makehint -f makehint_top.f

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all build run lint clean

//--- sim/tb_makehint.sv
// Testbench for the hint packing stage: clock, reset, r and z memory models,
// stimulus, the reference write list and the closing report

`timescale 1ns/100ps

module tb_makehint;

    localparam int RUN_TIMEOUT = 1000;
    localparam int DONE_CYCLES = 533;
    localparam makehint_pkg::coeff_t HI_EDGE = makehint_pkg::MLDSA_Q - makehint_pkg::GAMMA2;
    localparam int Q_I = int'(makehint_pkg::MLDSA_Q);
    localparam int G2_I = int'(makehint_pkg::GAMMA2);
    localparam int HI_I = int'(HI_EDGE);

    logic clk;
    logic reset_n;
    logic zeroize;
    logic start;
    makehint_pkg::mem_addr_t mem_base_addr;
    makehint_pkg::mem_addr_t dest_base_addr;
    makehint_pkg::coeff_t [3:0] r = '0;
    logic [3:0] z = '0;
    makehint_pkg::mem_req_t mem_rd_req;
    makehint_pkg::mem_req_t z_rd_req;
    makehint_pkg::reg_wr_t reg_wr;
    logic done;
    logic invalid_h;

    // Memory contents and the expected write list handed to the checker
    makehint_pkg::coeff_t [3:0] r_mem [1024];
    logic [3:0] z_mem [1024];
    makehint_pkg::reg_wr_t exp_wr [1024];
    int exp_cnt = 0;
    logic exp_invalid = 1'b0;
    logic last_invalid;
    int tb_errors = 0;
    int req_errors = 0;
    int chk_errors;
    makehint_pkg::mem_req_t r_req;
    makehint_pkg::mem_req_t z_req;
    // Data of the first register write of the running job
    makehint_pkg::dword_t first_wr;
    logic first_seen = 1'b0;

    makehint_top UUT (.*);

    makehint_checker u_checker (.*, .err_cnt(chk_errors));

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Memory models, request taken on the edge and answered 1 ns later
    // ------------------------------------------------------------------------
    always @(posedge clk) begin
        r_req = mem_rd_req;
        z_req = z_rd_req;
        #1;
        if (r_req.rd_en) begin
            r = r_mem[r_req.addr];
        end
        if (z_req.rd_en) begin
            z = z_mem[z_req.addr];
        end
        // z requests run from 0 while r requests run from the base
        if ((r_req.rd_en !== z_req.rd_en) || (r_req.rd_en &&
            (r_req.addr !== 10'(mem_base_addr + z_req.addr)))) begin
            $display("ERR t=%0t mem_rd_req.addr exp=%h got=%h", $time,
                     10'(mem_base_addr + z_req.addr), r_req.addr);
            req_errors++;
        end
    end

    // A start seen on the edge opens a new job
    always @(posedge clk) begin
        if (start) begin
            first_seen = 1'b0;
        end else if (reg_wr.wren && !first_seen) begin
            first_wr   = reg_wr.data;
            first_seen = 1'b1;
        end
    end

    // Random fill, per_mille of the coefficients land inside the hint band
    task automatic fill_mem(input int per_mille);
        int sel;
        for (int a = 0; a < 1024; a++) begin
            for (int l = 0; l < 4; l++) begin
                sel = $urandom_range(999, 0);
                if (sel < per_mille) begin
                    r_mem[a][l] = 23'($urandom_range(HI_I - 1, G2_I + 1));
                end else if ($urandom_range(1, 0) == 0) begin
                    r_mem[a][l] = 23'($urandom_range(G2_I, 0));
                end else begin
                    // The upper edge itself is left out so z never matters here
                    r_mem[a][l] = 23'($urandom_range(Q_I - 1, HI_I + 1));
                end
            end
            z_mem[a] = 4'($urandom);
        end
    endtask

    function automatic logic expect_hint(input int v, input logic zb);
        return ((v > G2_I) && (v < HI_I)) || ((v == HI_I) && zb);
    endfunction

    function automatic void add_write(input makehint_pkg::mem_addr_t dbase, input int off,
                                      input makehint_pkg::dword_t d);
        exp_wr[exp_cnt] = '{wren: 1'b1, addr: 10'(int'(dbase) + off), data: d};
        exp_cnt++;
    endfunction

    // ------------------------------------------------------------------------
    // Reference model, ordered list of every register write of one job
    // ------------------------------------------------------------------------
    function automatic void build_expected(input makehint_pkg::mem_addr_t mbase,
                                           input makehint_pkg::mem_addr_t dbase);
        logic [7:0] pend [$];
        logic [7:0] cnt [8];
        makehint_pkg::dword_t d;
        int total;
        int off;
        int word;
        total = 0;
        off = 0;
        exp_cnt = 0;
        for (int p = 0; p < 8; p++) begin
            for (int w = 0; w < 64; w++) begin
                word = p * 64 + w;
                for (int l = 0; l < 4; l++) begin
                    if (expect_hint(int'(r_mem[10'(int'(mbase) + word)][l]), z_mem[word][l])) begin
                        pend.push_back(8'(w * 4 + l));
                        total++;
                    end
                end
                // At most one dword per word, oldest index in byte 0
                if (pend.size() >= 4) begin
                    for (int i = 0; i < 4; i++) begin
                        d[8*i +: 8] = pend.pop_front();
                    end
                    add_write(dbase, off, d);
                    off++;
                end
            end
            cnt[p] = 8'(total);
        end
        d = '0;
        for (int i = 0; i < pend.size(); i++) begin
            d[8*i +: 8] = pend[i];
        end
        add_write(dbase, off, d);
        // Count area, later writes simply overwrite any index dwords there
        off = makehint_pkg::SUM_DWORD;
        add_write(dbase, off, {cnt[0], 24'h0});
        add_write(dbase, off + 1, {cnt[4], cnt[3], cnt[2], cnt[1]});
        add_write(dbase, off + 2, {8'h0, cnt[7], cnt[6], cnt[5]});
        exp_invalid = (total > makehint_pkg::OMEGA);
    endfunction

    task automatic launch(input makehint_pkg::mem_addr_t mbase,
                          input makehint_pkg::mem_addr_t dbase);
        mem_base_addr = mbase;
        dest_base_addr = dbase;
        build_expected(mbase, dbase);
        // invalid_h is sticky from the previous job until this start
        if (invalid_h !== last_invalid) begin
            $display("ERR t=%0t invalid_h exp=%b got=%b", $time, last_invalid, invalid_h);
            tb_errors++;
        end
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        if (invalid_h !== 1'b0) begin
            $display("ERR t=%0t invalid_h exp=0 got=%b", $time, invalid_h);
            tb_errors++;
        end
    endtask

    task automatic run_job(input makehint_pkg::mem_addr_t mbase,
                           input makehint_pkg::mem_addr_t dbase);
        int cycles;
        launch(mbase, dbase);
        cycles = 1;
        while (!done && cycles < RUN_TIMEOUT) begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!done) begin
            $display("Timeout: done still low %0d cycles after start", cycles);
            tb_errors++;
        end else if (cycles != DONE_CYCLES) begin
            $display("ERR t=%0t done cycles exp=%0d got=%0d", $time, DONE_CYCLES, cycles);
            tb_errors++;
        end
        last_invalid = exp_invalid;
        // One more edge so the checker closes the job on the old list
        @(posedge clk);
        #1;
    endtask

    task automatic abort_job(input int cycles_in);
        launch(10'h000, 10'h000);
        repeat (cycles_in) begin
            @(posedge clk);
            #1;
        end
        zeroize = 1'b1;
        @(posedge clk);
        #1;
        zeroize = 1'b0;
        if (done !== 1'b1) begin
            $display("ERR t=%0t done exp=1 got=%b", $time, done);
            tb_errors++;
        end
        // The checker flags any write in this quiet window
        repeat (20) begin
            @(posedge clk);
            #1;
        end
        last_invalid = 1'b0;
    endtask

    initial begin
        void'($urandom(32'h1ac8_79a7));
        reset_n = 1'b0;
        zeroize = 1'b0;
        start = 1'b0;
        mem_base_addr = '0;
        dest_base_addr = '0;
        last_invalid = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset_n = 1'b1;
        @(posedge clk);
        #1;

        // Sparse random hints
        fill_mem(3);
        run_job(10'h000, 10'h000);

        // Band edges: GAMMA2, GAMMA2+1, upper edge with z 0 and 1, edge-1
        fill_mem(0);
        r_mem[0][0] = makehint_pkg::GAMMA2;
        r_mem[0][1] = makehint_pkg::GAMMA2 + 23'd1;
        r_mem[0][2] = HI_EDGE;
        r_mem[0][3] = HI_EDGE;
        z_mem[0] = 4'b1011;
        r_mem[1][0] = HI_EDGE - 23'd1;
        r_mem[1][1] = HI_EDGE;
        z_mem[1] = 4'b1101;
        run_job(10'h000, 10'h000);
        // Only indices 1, 3 and 4 are hints, so the flush dword comes first
        if (first_wr !== 32'h0004_0301) begin
            $display("ERR t=%0t reg_wr.data exp=%h got=%h", $time,
                     32'h0004_0301, first_wr);
            tb_errors++;
        end

        // No hints, one zero flush dword and zero counts
        fill_mem(0);
        run_job(10'h000, 10'h000);

        // Far more than OMEGA hints
        fill_mem(100);
        run_job(10'h000, 10'h000);

        // Shifted bases, invalid_h from the last job clears on start
        fill_mem(20);
        run_job(10'h1f3, 10'h2a5);

        // zeroize part way through, then a clean job
        fill_mem(3);
        abort_job(150);
        run_job(10'h000, 10'h000);

        $display("Errors: checker %0d, testbench %0d, read requests %0d",
                 chk_errors, tb_errors, req_errors);
        if (chk_errors + tb_errors + req_errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

//--- sim/makehint_checker.sv
// Register-write checker, compares each DUT write in order with the
// expected list and checks the write count and invalid_h at done

`timescale 1ns/100ps

module makehint_checker (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    start,
    input  logic                    zeroize,
    input  makehint_pkg::reg_wr_t   reg_wr,
    input  logic                    done,
    input  logic                    invalid_h,
    input  makehint_pkg::reg_wr_t   exp_wr [1024],
    input  int                      exp_cnt,
    input  logic                    exp_invalid,
    output int                      err_cnt
);

    int errors = 0;
    int wr_idx;
    logic active;
    // Set by zeroize, the job then ends without its remaining writes
    logic aborted;
    logic done_q;

    assign err_cnt = errors;

    always @(posedge clk) begin
        if (!reset_n) begin
            wr_idx  = 0;
            active  = 1'b0;
            aborted = 1'b0;
            done_q  = 1'b1;
        end else begin
            // Writes of this edge belong to the cycle before any zeroize seen here
            if (reg_wr.wren) begin
                if (!active || aborted) begin
                    $display("%0t: write to %h outside a running job or after zeroize",
                             $time, reg_wr.addr);
                    errors++;
                end else if (wr_idx >= exp_cnt) begin
                    $display("%0t: extra write to %h, only %0d writes expected",
                             $time, reg_wr.addr, exp_cnt);
                    errors++;
                end else begin
                    if (reg_wr.addr !== exp_wr[wr_idx].addr) begin
                        $display("ERR t=%0t reg_wr.addr exp=%h got=%h", $time,
                                 exp_wr[wr_idx].addr, reg_wr.addr);
                        errors++;
                    end
                    if (reg_wr.data !== exp_wr[wr_idx].data) begin
                        $display("ERR t=%0t reg_wr.data exp=%h got=%h", $time,
                                 exp_wr[wr_idx].data, reg_wr.data);
                        errors++;
                    end
                end
                wr_idx++;
            end
            if (zeroize) begin
                aborted = 1'b1;
            end
            // Rising done closes a complete job
            if (done && !done_q && active && !aborted) begin
                if (wr_idx != exp_cnt) begin
                    $display("%0t: job ended after %0d writes, %0d expected",
                             $time, wr_idx, exp_cnt);
                    errors++;
                end
                if (invalid_h !== exp_invalid) begin
                    $display("ERR t=%0t invalid_h exp=%b got=%b", $time,
                             exp_invalid, invalid_h);
                    errors++;
                end
                active = 1'b0;
            end
            if (start) begin
                wr_idx  = 0;
                active  = 1'b1;
                aborted = 1'b0;
            end
            done_q = done;
        end
    end

endmodule

//--- src/makehint_top.sv
// Top level of the hint packing stage, wiring the counters,
// FSM, hint lanes, index buffer and register writer

`timescale 1ns/100ps

module makehint_top (
    input  logic                           clk,
    input  logic                           reset_n,
    input  logic                           zeroize,
    input  logic                           start,
    input  makehint_pkg::mem_addr_t        mem_base_addr,
    input  makehint_pkg::mem_addr_t        dest_base_addr,
    input  makehint_pkg::coeff_t [3:0]     r,
    input  logic [3:0]                     z,
    output makehint_pkg::mem_req_t         mem_rd_req,
    output makehint_pkg::mem_req_t         z_rd_req,
    output makehint_pkg::reg_wr_t          reg_wr,
    output logic                           done,
    output logic                           invalid_h
);

    makehint_pkg::mh_ctrl_t ctrl;
    logic last_addr;
    logic poly_last;
    logic idx_valid;
    makehint_pkg::hint_idx_t [3:0] idx;
    makehint_pkg::poly_cnt_t poly_cnt;
    logic [3:0] hint;
    logic buf_valid;
    makehint_pkg::dword_t buf_data;

    makehint_fsm u_fsm (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .start(start),
        .last_addr(last_addr), .poly_last(poly_last), .ctrl(ctrl), .done(done)
    );

    makehint_counter u_counter (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .ctrl(ctrl),
        .mem_base_addr(mem_base_addr), .mem_rd_req(mem_rd_req), .z_rd_req(z_rd_req),
        .last_addr(last_addr), .poly_last(poly_last), .idx_valid(idx_valid),
        .idx(idx), .poly_cnt(poly_cnt)
    );

    // The read-enable level arms the lanes for data one cycle later
    hint_gen u_hint_gen (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .enable(mem_rd_req.rd_en),
        .r(r), .z(z), .hint(hint)
    );

    hint_index_buffer u_buffer (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .flush(ctrl.flush),
        .hint(hint), .idx(idx), .out_valid(buf_valid), .out_data(buf_data)
    );

    hint_writer u_writer (
        .clk(clk), .reset_n(reset_n), .zeroize(zeroize), .start(start), .ctrl(ctrl),
        .hint(hint), .buf_valid(buf_valid), .buf_data(buf_data),
        .dest_base_addr(dest_base_addr), .reg_wr(reg_wr), .invalid_h(invalid_h)
    );

    // Hints from hint_gen only ever line up with a valid index word
    a_hint_has_idx: assert property (@(posedge clk) disable iff (!reset_n)
        (hint != 4'h0) |-> idx_valid);

    // The flag-memory word address names the polynomial being read,
    // so it has to agree with the polynomial counter on every read
    a_poly_in_step: assert property (@(posedge clk) disable iff (!reset_n)
        z_rd_req.rd_en |-> z_rd_req.addr[8:6] == poly_cnt);

endmodule

//--- src/hint_writer.sv
// Running hint sum, per-polynomial count buffer, sticky invalid
// flag and the register-API write mux with its offset

`timescale 1ns/100ps

module hint_writer (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     zeroize,
    input  logic                     start,
    input  makehint_pkg::mh_ctrl_t   ctrl,
    input  logic [3:0]               hint,
    input  logic                     buf_valid,
    input  makehint_pkg::dword_t     buf_data,
    input  makehint_pkg::mem_addr_t  dest_base_addr,
    output makehint_pkg::reg_wr_t    reg_wr,
    output logic                     invalid_h
);

    makehint_pkg::hint_sum_t hint_sum;
    makehint_pkg::hint_sum_t sum_nxt;
    // Entry 0 ends up holding polynomial 0 after all eight shifts
    makehint_pkg::hint_sum_t [makehint_pkg::MLDSA_K-1:0] poly_sums;
    makehint_pkg::mem_addr_t wr_off;
    makehint_pkg::dword_t sum_dword;
    logic sum_phase;
    logic wr_fire;

    // incr_poly meets the last hints of a polynomial, so the new sum is stored
    assign sum_nxt = hint_sum + 8'($countones(hint));

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            hint_sum  <= '0;
            poly_sums <= '0;
            invalid_h <= 1'b0;
        end else if (zeroize || start) begin
            hint_sum  <= '0;
            poly_sums <= '0;
            invalid_h <= 1'b0;
        end else begin
            hint_sum <= sum_nxt;
            if (ctrl.incr_poly) begin
                poly_sums <= {sum_nxt, poly_sums[makehint_pkg::MLDSA_K-1:1]};
            end
            // Sticky until the next run, even if the 8-bit sum wraps
            if (sum_nxt > 8'(makehint_pkg::OMEGA)) begin
                invalid_h <= 1'b1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Count dword layout
    // ------------------------------------------------------------------------
    always_comb begin
        case (ctrl.sum_sel)
            2'd1:    sum_dword = {poly_sums[0], 24'h0};
            2'd2:    sum_dword = poly_sums[4:1];
            2'd3:    sum_dword = {8'h0, poly_sums[7:5]};
            default: sum_dword = '0;
        endcase
    end

    assign sum_phase = (ctrl.sum_sel != 2'd0);
    assign wr_fire   = buf_valid || ctrl.flush || sum_phase;

    // Offset counts dwords from 0, then jumps to the count area
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            wr_off <= '0;
        end else if (zeroize || ctrl.rst_addr) begin
            wr_off <= '0;
        end else if (ctrl.sum_addr) begin
            wr_off <= 10'(makehint_pkg::SUM_DWORD);
        end else if (wr_fire) begin
            wr_off <= wr_off + 1'b1;
        end
    end

    assign reg_wr.wren = wr_fire;
    assign reg_wr.addr = dest_base_addr + wr_off;
    assign reg_wr.data = sum_phase ? sum_dword : buf_data;

    // Index dwords must be done before the FSM reaches the count writes
    a_no_buf_in_sum: assert property (@(posedge clk) disable iff (!reset_n)
        sum_phase |-> !buf_valid);

endmodule

//--- src/makehint_counter.sv
// Read-address, coefficient-index and polynomial counters
// with the end-of-polynomial detect

`timescale 1ns/100ps

module makehint_counter (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  makehint_pkg::mh_ctrl_t          ctrl,
    input  makehint_pkg::mem_addr_t         mem_base_addr,
    output makehint_pkg::mem_req_t          mem_rd_req,
    output makehint_pkg::mem_req_t          z_rd_req,
    output logic                            last_addr,
    output logic                            poly_last,
    output logic                            idx_valid,
    output makehint_pkg::hint_idx_t [3:0]   idx,
    output makehint_pkg::poly_cnt_t         poly_cnt
);

    makehint_pkg::mem_addr_t rd_addr;
    makehint_pkg::mem_addr_t z_addr;
    makehint_pkg::hint_idx_t idx_base;
    logic rd_d1;
    logic rd_d2;

    // Both addresses step together, r from its base and z from 0
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_addr <= '0;
            z_addr  <= '0;
        end else if (zeroize) begin
            rd_addr <= '0;
            z_addr  <= '0;
        end else if (ctrl.rst_addr) begin
            rd_addr <= mem_base_addr;
            z_addr  <= '0;
        end else if (ctrl.rd_active) begin
            rd_addr <= rd_addr + 1'b1;
            z_addr  <= z_addr + 1'b1;
        end
    end

    assign mem_rd_req = '{rd_en: ctrl.rd_active, addr: rd_addr};
    assign z_rd_req   = '{rd_en: ctrl.rd_active, addr: z_addr};

    // The low bits of the z address give the word within the polynomial
    assign last_addr = (z_addr[5:0] == 6'(makehint_pkg::WORDS_PER_POLY - 1));

    // ------------------------------------------------------------------------
    // Index pipeline, one cycle memory latency plus one in hint_gen
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_d1    <= 1'b0;
            rd_d2    <= 1'b0;
            idx_base <= '0;
            poly_cnt <= '0;
        end else if (zeroize) begin
            rd_d1    <= 1'b0;
            rd_d2    <= 1'b0;
            idx_base <= '0;
            poly_cnt <= '0;
        end else begin
            rd_d1 <= ctrl.rd_active;
            rd_d2 <= rd_d1;
            // 64 words of four wrap the 8-bit index back to 0 per polynomial
            if (ctrl.rst_addr) begin
                idx_base <= '0;
            end else if (rd_d2) begin
                idx_base <= idx_base + 8'd4;
            end
            if (ctrl.rst_addr) begin
                poly_cnt <= '0;
            end else if (ctrl.incr_poly) begin
                poly_cnt <= poly_cnt + 1'b1;
            end
        end
    end

    assign idx_valid = rd_d2;
    assign poly_last = (poly_cnt == 3'(makehint_pkg::MLDSA_K - 1));

    always_comb begin
        for (int i = 0; i < 4; i++) begin
            idx[i] = idx_base + 8'(i);
        end
    end

endmodule

//--- src/makehint_fsm.sv
// Sequencing FSM for reading, pipeline drain, flush and the
// three hint count writes

`timescale 1ns/100ps

module makehint_fsm (
    input  logic                    clk,
    input  logic                    reset_n,
    input  logic                    zeroize,
    input  logic                    start,
    input  logic                    last_addr,
    input  logic                    poly_last,
    output makehint_pkg::mh_ctrl_t  ctrl,
    output logic                    done
);

    makehint_pkg::mh_state_e state;
    makehint_pkg::mh_state_e state_nxt;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state <= makehint_pkg::MH_IDLE;
        end else if (zeroize) begin
            state <= makehint_pkg::MH_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // ------------------------------------------------------------------------
    // Next state and control decode
    // ------------------------------------------------------------------------
    always_comb begin
        state_nxt = state;
        ctrl      = '0;
        unique case (state)
            makehint_pkg::MH_IDLE: begin
                // Base addresses are loaded every idle cycle
                ctrl.rst_addr = 1'b1;
                if (start) begin
                    state_nxt = makehint_pkg::MH_RD_MEM;
                end
            end
            makehint_pkg::MH_RD_MEM: begin
                ctrl.rd_active = 1'b1;
                if (last_addr) begin
                    state_nxt = makehint_pkg::MH_WAIT1;
                end
            end
            // Two idle cycles let the memory and hint_gen stages drain
            makehint_pkg::MH_WAIT1: begin
                state_nxt = makehint_pkg::MH_WAIT2;
            end
            makehint_pkg::MH_WAIT2: begin
                // The last hints of this polynomial are on the bus now
                ctrl.incr_poly = 1'b1;
                state_nxt = poly_last ? makehint_pkg::MH_FLUSH : makehint_pkg::MH_RD_MEM;
            end
            makehint_pkg::MH_FLUSH: begin
                ctrl.flush    = 1'b1;
                ctrl.sum_addr = 1'b1;
                state_nxt     = makehint_pkg::MH_SUM_LO;
            end
            makehint_pkg::MH_SUM_LO: begin
                ctrl.sum_sel = 2'd1;
                state_nxt    = makehint_pkg::MH_SUM_MID;
            end
            makehint_pkg::MH_SUM_MID: begin
                ctrl.sum_sel = 2'd2;
                state_nxt    = makehint_pkg::MH_SUM_HI;
            end
            makehint_pkg::MH_SUM_HI: begin
                ctrl.sum_sel = 2'd3;
                state_nxt    = makehint_pkg::MH_IDLE;
            end
            default: begin
                state_nxt = makehint_pkg::MH_IDLE;
            end
        endcase
    end

    assign done = (state == makehint_pkg::MH_IDLE);

    // The controller never restarts a run that is still in flight
    a_start_idle: assert property (@(posedge clk) disable iff (!reset_n || zeroize)
        start |-> state == makehint_pkg::MH_IDLE);

endmodule

//--- src/hint_index_buffer.sv
// Packs indices of set hints into dwords, oldest index in byte 0,
// and flushes the remainder padded with zeros

`timescale 1ns/100ps

module hint_index_buffer (
    input  logic                            clk,
    input  logic                            reset_n,
    input  logic                            zeroize,
    input  logic                            flush,
    input  logic [3:0]                      hint,
    input  makehint_pkg::hint_idx_t [3:0]   idx,
    output logic                            out_valid,
    output makehint_pkg::dword_t            out_data
);

    // Held bytes, entries past the fill level are always zero
    makehint_pkg::hint_idx_t [6:0] store;
    makehint_pkg::hint_idx_t [6:0] merged;
    logic [2:0] fill;
    logic [3:0] merged_cnt;

    // ------------------------------------------------------------------------
    // Append the indices of set lanes behind the held bytes, in lane order
    // ------------------------------------------------------------------------
    always_comb begin
        merged     = store;
        merged_cnt = {1'b0, fill};
        for (int i = 0; i < 4; i++) begin
            if (hint[i]) begin
                if (merged_cnt < 4'd7) begin
                    merged[merged_cnt[2:0]] = idx[i];
                end
                merged_cnt = merged_cnt + 4'd1;
            end
        end
    end

    // A dword leaves in the same cycle its fourth index arrives
    // On flush the low four bytes hold the remainder, already zero padded
    assign out_valid = (merged_cnt >= 4'd4);
    assign out_data  = merged[3:0];

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            store <= '0;
            fill  <= '0;
        end else if (zeroize || flush) begin
            store <= '0;
            fill  <= '0;
        end else if (out_valid) begin
            // Drop the emitted dword and shift the rest down to byte 0
            store <= {32'h0, merged[6:4]};
            fill  <= 3'(merged_cnt - 4'd4);
        end else begin
            store <= merged;
            fill  <= merged_cnt[2:0];
        end
    end

    // At most three bytes stay behind, so four new ones never overrun
    a_occupancy: assert property (@(posedge clk) disable iff (!reset_n)
        merged_cnt <= 4'd7);

endmodule

//--- src/hint_gen.sv
// Four-lane registered hint computation from r coefficients
// and the matching z-differs flags

`timescale 1ns/100ps

module hint_gen (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         zeroize,
    input  logic                         enable,
    input  makehint_pkg::coeff_t [3:0]   r,
    input  logic [3:0]                   z,
    output logic [3:0]                   hint
);

    // Upper edge of the no-hint band, where z decides
    localparam makehint_pkg::coeff_t HI_BOUND = makehint_pkg::MLDSA_Q - makehint_pkg::GAMMA2;

    logic       en_q;
    logic [3:0] hint_nxt;

    // Per lane the hint is set strictly inside the band, or on its
    // upper edge when the z flag of that lane is set
    always_comb begin
        for (int i = 0; i < makehint_pkg::COEFF_PER_WORD; i++) begin
            hint_nxt[i] = ((r[i] > makehint_pkg::GAMMA2) && (r[i] < HI_BOUND)) ||
                          ((r[i] == HI_BOUND) && z[i]);
        end
    end

    // enable is the read-enable level of the request
    // The memory answers a cycle later, so it is delayed once to meet r and z
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            en_q <= 1'b0;
            hint <= '0;
        end else if (zeroize) begin
            en_q <= 1'b0;
            hint <= '0;
        end else begin
            en_q <= enable;
            // Stale memory data outside a read window must not make hints
            hint <= en_q ? hint_nxt : '0;
        end
    end

endmodule

//--- src/makehint_pkg.sv
// Shared constants, width types, FSM states and signal bundles
// for the ML-DSA-87 hint packing stage

package makehint_pkg;

    // ------------------------------------------------------------------------
    // Width types
    // ------------------------------------------------------------------------
    localparam int MEM_ADDR_W = 10;

    typedef logic [22:0]           coeff_t;
    typedef logic [MEM_ADDR_W-1:0] mem_addr_t;
    typedef logic [7:0]            hint_idx_t;
    typedef logic [7:0]            hint_sum_t;
    typedef logic [31:0]           dword_t;
    typedef logic [2:0]            poly_cnt_t;

    // ------------------------------------------------------------------------
    // Algorithm constants
    // ------------------------------------------------------------------------
    localparam coeff_t MLDSA_Q = 23'd8380417;
    // Decomposition bound (Q-1)/32 used by the hint rule
    localparam coeff_t GAMMA2 = 23'd261888;
    localparam int MLDSA_N = 256;
    localparam int MLDSA_K = 8;
    localparam int OMEGA = 75;
    localparam int COEFF_PER_WORD = 4;
    localparam int WORDS_PER_POLY = MLDSA_N / COEFF_PER_WORD;
    // The count area starts right after the OMEGA index bytes
    localparam int SUM_DWORD = OMEGA / 4;

    // Sequencer states, one polynomial is RD_MEM x64 then WAIT1 and WAIT2
    typedef enum logic [2:0] {
        MH_IDLE,
        MH_RD_MEM,
        MH_WAIT1,
        MH_WAIT2,
        MH_FLUSH,
        MH_SUM_LO,
        MH_SUM_MID,
        MH_SUM_HI
    } mh_state_e;

    // Read request shared by the coefficient and flag memories
    typedef struct packed {
        logic      rd_en;
        mem_addr_t addr;
    } mem_req_t;

    // Single-cycle write into the register API
    typedef struct packed {
        logic      wren;
        mem_addr_t addr;
        dword_t    data;
    } reg_wr_t;

    // Steering bundle from the FSM, sum_sel is 1 low, 2 middle, 3 high
    typedef struct packed {
        logic       rst_addr;
        logic       rd_active;
        logic       incr_poly;
        logic       flush;
        logic [1:0] sum_sel;
        logic       sum_addr;
    } mh_ctrl_t;

endpackage
